// ==== hdl/xt_bus_pkg.sv ====
package xt_bus_pkg;

  // high-speed bus byte address
  localparam int HB_ADDR_WIDTH = 18;
  // low-speed bus offset inside its domain
  localparam int LB_ADDR_WIDTH = 8;

  // store size, data sits in the low bits
  typedef enum logic [1:0] {
    WIDTH_BYTE = 2'd0,
    WIDTH_HALF = 2'd1,
    WIDTH_WORD = 2'd2
  } write_width_t;

  // address map
  localparam logic [HB_ADDR_WIDTH-1:0] RAM_BASE      = 18'h0_0000;
  localparam logic [HB_ADDR_WIDTH-1:0] LB_BASE       = 18'h1_0000;
  localparam logic [HB_ADDR_WIDTH-1:0] UNMAPPED_BASE = 18'h2_0000;

  // high-speed domains
  localparam int ID_RAM   = 0;
  localparam int ID_XT_LB = 1;

  // low-speed slaves, one word each
  localparam int LB_ID_SW_KEY = 0;
  localparam int LB_ID_LED    = 1;

endpackage

// ==== hdl/xt_hb.sv ====
`timescale 1ns/100ps

module xt_hb
  import xt_bus_pkg::*;
#(
  parameter int DOMAIN_NUM = 2
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  // master side
  input  logic                     read_i,
  input  logic                     write_i,
  input  logic [HB_ADDR_WIDTH-1:0] raddr_i,
  input  logic [HB_ADDR_WIDTH-1:0] waddr_i,
  input  logic [31:0]              wdata_i,
  input  write_width_t             write_width_i,
  output logic [31:0]              rdata_o,
  output logic                     stall_o,
  // domain side
  input  logic [DOMAIN_NUM-1:0]    read_finish_i,
  input  logic [DOMAIN_NUM-1:0]    write_finish_i,
  input  logic [31:0]              domain_rdata_i [DOMAIN_NUM],
  output logic [DOMAIN_NUM-1:0]    domain_sel_o,
  output logic [HB_ADDR_WIDTH-1:0] addr_o,
  output logic [31:0]              wdata_o,
  output write_width_t             write_width_o,
  output logic                     read_o,
  output logic                     write_o
);

  logic                  req;
  logic [DOMAIN_NUM-1:0] hit;
  logic                  unmapped;
  logic                  unmap_done;
  logic                  finish_any;

  assign req = read_i | write_i;

  // read and write never overlap
  assign addr_o        = read_i ? raddr_i : waddr_i;
  assign wdata_o       = wdata_i;
  assign write_width_o = write_width_i;
  assign read_o        = read_i;
  assign write_o       = write_i;

  // address map decode
  always_comb begin
    hit      = '0;
    unmapped = 1'b0;
    if (addr_o < LB_BASE) begin
      hit[ID_RAM] = 1'b1;
    end else if (addr_o < UNMAPPED_BASE) begin
      hit[ID_XT_LB] = 1'b1;
    end else begin
      unmapped = 1'b1;
    end
  end

  assign domain_sel_o = req ? hit : '0;

  // nobody answers above the map, so finish here after one cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      unmap_done <= 1'b0;
    end else begin
      unmap_done <= req & unmapped & ~finish_any;
    end
  end

  assign finish_any = (|read_finish_i) | (|write_finish_i) | unmap_done;
  assign stall_o    = req & ~finish_any;

  // unmapped reads fall through as 0
  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < DOMAIN_NUM; i++) begin
      if (read_finish_i[i]) begin
        rdata_o = domain_rdata_i[i];
      end
    end
  end

endmodule

// ==== hdl/system_ram_bus.sv ====
`timescale 1ns/100ps

module system_ram_bus
  import xt_bus_pkg::*;
#(
  parameter int RAM_DEPTH = 256
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     sel_i,
  input  logic                     read_i,
  input  logic                     write_i,
  input  logic [HB_ADDR_WIDTH-1:0] addr_i,
  input  logic [31:0]              wdata_i,
  input  write_width_t             write_width_i,
  output logic [31:0]              rdata_o,
  output logic                     read_finish_o,
  output logic                     write_finish_o
);

  localparam int IDX_W = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

  logic [31:0]              mem [RAM_DEPTH];
  logic [HB_ADDR_WIDTH-1:0] offset;
  logic [IDX_W-1:0]         idx;
  logic                     done;
  logic                     rd_go;
  logic                     wr_go;
  logic [3:0]               be;
  logic [31:0]              lane_data;

  assign offset = addr_i - RAM_BASE;
  assign idx    = offset[IDX_W+1:2];

  // ignore the held select in the finishing cycle
  assign done  = read_finish_o | write_finish_o;
  assign rd_go = sel_i & read_i & ~done;
  assign wr_go = sel_i & write_i & ~done;

  // byte lanes from size and low address bits
  always_comb begin
    case (write_width_i)
      WIDTH_BYTE: begin
        be        = 4'b0001 << offset[1:0];
        lane_data = {4{wdata_i[7:0]}};
      end
      WIDTH_HALF: begin
        be        = offset[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{wdata_i[15:0]}};
      end
      default: begin
        be        = 4'b1111;
        lane_data = wdata_i;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          mem[idx][8*b +: 8] <= lane_data[8*b +: 8];
        end
      end
    end
    // full word, the core picks the sub-word
    if (rd_go) begin
      rdata_o <= mem[idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      read_finish_o  <= 1'b0;
      write_finish_o <= 1'b0;
    end else begin
      read_finish_o  <= rd_go;
      write_finish_o <= wr_go;
    end
  end

endmodule

// ==== hdl/xt_lb.sv ====
`timescale 1ns/100ps

module xt_lb
  import xt_bus_pkg::*;
#(
  parameter int LB_DIV       = 4,
  parameter int LB_SLAVE_NUM = 2
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  // high-speed side
  input  logic                     sel_i,
  input  logic                     read_i,
  input  logic                     write_i,
  input  logic [HB_ADDR_WIDTH-1:0] addr_i,
  input  logic [31:0]              wdata_i,
  output logic                     read_finish_o,
  output logic                     write_finish_o,
  output logic [31:0]              rdata_o,
  // low-speed side
  output logic [LB_SLAVE_NUM-1:0]  lb_sel_o,
  output logic [LB_ADDR_WIDTH-1:0] lb_addr_o,
  output logic [31:0]              lb_wdata_o,
  output logic                     lb_read_o,
  output logic                     lb_write_o,
  input  logic [31:0]              lb_rdata_i [LB_SLAVE_NUM]
);

  localparam int DIV_W = (LB_DIV > 1) ? $clog2(LB_DIV) : 1;

  typedef enum logic [1:0] {S_IDLE, S_WAIT, S_STROBE, S_CAPTURE} state_t;

  state_t                   state;
  logic [DIV_W-1:0]         div_cnt;
  logic                     tick;
  logic                     op_read;
  logic [LB_SLAVE_NUM-1:0]  hit;
  logic [LB_SLAVE_NUM-1:0]  sel_q;
  logic [LB_ADDR_WIDTH-1:0] addr_q;
  logic [31:0]              wdata_q;

  // tick stands in for the slow bus clock
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign tick = (div_cnt == DIV_W'(LB_DIV - 1));

  // one slave per word offset
  always_comb begin
    for (int i = 0; i < LB_SLAVE_NUM; i++) begin
      hit[i] = (addr_i[LB_ADDR_WIDTH-1:2] == (LB_ADDR_WIDTH-2)'(i));
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state   <= S_IDLE;
      op_read <= 1'b0;
      sel_q   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (sel_i & (read_i | write_i)) begin
            op_read <= read_i;
            sel_q   <= hit;
            state   <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (tick) begin
            state <= S_STROBE;
          end
        end
        S_STROBE: state <= S_CAPTURE;
        default:  state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      addr_q  <= addr_i[LB_ADDR_WIDTH-1:0];
      wdata_q <= wdata_i;
    end
  end

  assign lb_sel_o   = (state == S_STROBE) ? sel_q : '0;
  assign lb_read_o  = (state == S_STROBE) & op_read;
  assign lb_write_o = (state == S_STROBE) & ~op_read;
  assign lb_addr_o  = addr_q;
  assign lb_wdata_o = wdata_q;

  // slave registered its data on the strobe
  assign read_finish_o  = (state == S_CAPTURE) & op_read;
  assign write_finish_o = (state == S_CAPTURE) & ~op_read;

  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < LB_SLAVE_NUM; i++) begin
      if (sel_q[i]) begin
        rdata_o = lb_rdata_i[i];
      end
    end
  end

endmodule

// ==== hdl/sw_key_lbus.sv ====
`timescale 1ns/100ps

module sw_key_lbus #(
  parameter int DEBOUNCE_CNT = 16
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [3:0]  key_raw_i,
  input  logic [1:0]  sw_raw_i,
  input  logic        lb_sel_i,
  input  logic        lb_read_i,
  input  logic        lb_write_i,
  input  logic [31:0] lb_wdata_i,
  output logic [31:0] lb_rdata_o
);

  localparam int IN_NUM = 6;
  localparam int CNT_W  = $clog2(DEBOUNCE_CNT + 1);

  logic [IN_NUM-1:0] in_raw;
  logic [IN_NUM-1:0] sync_1;
  logic [IN_NUM-1:0] sync_2;
  logic [IN_NUM-1:0] stable;
  logic [CNT_W-1:0]  cnt [IN_NUM];
  logic [3:0]        key_d;
  logic [3:0]        press;
  logic [3:0]        clear;
  logic [3:0]        latch;

  // keys are active low on the pins
  assign in_raw = {sw_raw_i, ~key_raw_i};

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_1 <= '0;
      sync_2 <= '0;
    end else begin
      sync_1 <= in_raw;
      sync_2 <= sync_1;
    end
  end

  // take the new level once it held for DEBOUNCE_CNT cycles
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stable <= '0;
      for (int i = 0; i < IN_NUM; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < IN_NUM; i++) begin
        if (sync_2[i] == stable[i]) begin
          cnt[i] <= '0;
        end else if (cnt[i] == CNT_W'(DEBOUNCE_CNT - 1)) begin
          stable[i] <= sync_2[i];
          cnt[i]    <= '0;
        end else begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign press = stable[3:0] & ~key_d;
  // write 1 to clear a latch
  assign clear = (lb_sel_i & lb_write_i) ? lb_wdata_i[11:8] : 4'b0000;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      key_d <= '0;
      latch <= '0;
    end else begin
      key_d <= stable[3:0];
      latch <= (latch & ~clear) | press;
    end
  end

  always_ff @(posedge clk) begin
    if (lb_sel_i & lb_read_i) begin
      lb_rdata_o <= {20'b0, latch, 2'b0, stable};
    end
  end

endmodule

// ==== hdl/led_lbus.sv ====
`timescale 1ns/100ps

module led_lbus (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        lb_sel_i,
  input  logic        lb_read_i,
  input  logic        lb_write_i,
  input  logic [31:0] lb_wdata_i,
  output logic [31:0] lb_rdata_o,
  output logic [7:0]  led_o
);

  // led register, low byte of the write
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_o <= 8'h00;
    end else if (lb_sel_i & lb_write_i) begin
      led_o <= lb_wdata_i[7:0];
    end
  end

  // read back on the strobe
  always_ff @(posedge clk) begin
    if (lb_sel_i & lb_read_i) begin
      lb_rdata_o <= {24'b0, led_o};
    end
  end

endmodule

// ==== hdl/xt_soc.sv ====
`timescale 1ns/100ps

module xt_soc
  import xt_bus_pkg::*;
#(
  parameter int RAM_DEPTH    = 256,
  parameter int LB_DIV       = 4,
  parameter int DEBOUNCE_CNT = 16
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     read_i,
  input  logic                     write_i,
  input  logic [HB_ADDR_WIDTH-1:0] raddr_i,
  input  logic [HB_ADDR_WIDTH-1:0] waddr_i,
  input  logic [31:0]              wdata_i,
  input  write_width_t             write_width_i,
  input  logic [3:0]               key_raw_i,
  input  logic [1:0]               sw_raw_i,
  output logic [31:0]              rdata_o,
  output logic                     stall_o,
  output logic [7:0]               led_o
);

  // ram and low-speed bridge
  localparam int DOMAIN_NUM = 2;
  // sw/key and led
  localparam int LB_SLAVE_NUM = 2;

  // high-speed bus fan-out
  wire [DOMAIN_NUM-1:0]    domain_sel;
  wire [HB_ADDR_WIDTH-1:0] hb_addr;
  wire [31:0]              hb_wdata;
  wire write_width_t       hb_width;
  wire                     hb_read;
  wire                     hb_write;
  wire [DOMAIN_NUM-1:0]    read_finish;
  wire [DOMAIN_NUM-1:0]    write_finish;
  wire [31:0]              domain_rdata [DOMAIN_NUM];

  // low-speed bus
  wire [LB_SLAVE_NUM-1:0]  lb_sel;
  wire [31:0]              lb_wdata;
  wire                     lb_read;
  wire                     lb_write;
  wire [31:0]              lb_rdata [LB_SLAVE_NUM];

  xt_hb #(
    .DOMAIN_NUM(DOMAIN_NUM)
  ) u_xt_hb (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .read_i        (read_i),
    .write_i       (write_i),
    .raddr_i       (raddr_i),
    .waddr_i       (waddr_i),
    .wdata_i       (wdata_i),
    .write_width_i (write_width_i),
    .rdata_o       (rdata_o),
    .stall_o       (stall_o),
    .read_finish_i (read_finish),
    .write_finish_i(write_finish),
    .domain_rdata_i(domain_rdata),
    .domain_sel_o  (domain_sel),
    .addr_o        (hb_addr),
    .wdata_o       (hb_wdata),
    .write_width_o (hb_width),
    .read_o        (hb_read),
    .write_o       (hb_write)
  );

  system_ram_bus #(
    .RAM_DEPTH(RAM_DEPTH)
  ) u_system_ram_bus (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .sel_i         (domain_sel[ID_RAM]),
    .read_i        (hb_read),
    .write_i       (hb_write),
    .addr_i        (hb_addr),
    .wdata_i       (hb_wdata),
    .write_width_i (hb_width),
    .rdata_o       (domain_rdata[ID_RAM]),
    .read_finish_o (read_finish[ID_RAM]),
    .write_finish_o(write_finish[ID_RAM])
  );

  // slaves decode by their select alone, so the offset stays open
  xt_lb #(
    .LB_DIV      (LB_DIV),
    .LB_SLAVE_NUM(LB_SLAVE_NUM)
  ) u_xt_lb (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .sel_i         (domain_sel[ID_XT_LB]),
    .read_i        (hb_read),
    .write_i       (hb_write),
    .addr_i        (hb_addr),
    .wdata_i       (hb_wdata),
    .read_finish_o (read_finish[ID_XT_LB]),
    .write_finish_o(write_finish[ID_XT_LB]),
    .rdata_o       (domain_rdata[ID_XT_LB]),
    .lb_sel_o      (lb_sel),
    .lb_addr_o     (),
    .lb_wdata_o    (lb_wdata),
    .lb_read_o     (lb_read),
    .lb_write_o    (lb_write),
    .lb_rdata_i    (lb_rdata)
  );

  sw_key_lbus #(
    .DEBOUNCE_CNT(DEBOUNCE_CNT)
  ) u_sw_key_lbus (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .key_raw_i (key_raw_i),
    .sw_raw_i  (sw_raw_i),
    .lb_sel_i  (lb_sel[LB_ID_SW_KEY]),
    .lb_read_i (lb_read),
    .lb_write_i(lb_write),
    .lb_wdata_i(lb_wdata),
    .lb_rdata_o(lb_rdata[LB_ID_SW_KEY])
  );

  led_lbus u_led_lbus (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .lb_sel_i  (lb_sel[LB_ID_LED]),
    .lb_read_i (lb_read),
    .lb_write_i(lb_write),
    .lb_wdata_i(lb_wdata),
    .lb_rdata_o(lb_rdata[LB_ID_LED]),
    .led_o     (led_o)
  );

endmodule

// ==== bench/tb_xt_soc.sv ====
`timescale 1ns/100ps

module tb_xt_soc
  import xt_bus_pkg::*;
();

  localparam int RAM_DEPTH    = 64;
  localparam int LB_DIV       = 4;
  localparam int DEBOUNCE_CNT = 8;
  localparam int BUS_TIMEOUT  = 64;

  logic                     clk;
  logic                     rst_n_i;
  logic                     read_i;
  logic                     write_i;
  logic [HB_ADDR_WIDTH-1:0] raddr_i;
  logic [HB_ADDR_WIDTH-1:0] waddr_i;
  logic [31:0]              wdata_i;
  write_width_t             write_width_i;
  logic [3:0]               key_raw_i;
  logic [1:0]               sw_raw_i;
  logic [31:0]              rdata_o;
  logic                     stall_o;
  logic [7:0]               led_o;

  logic [31:0] ram_model [RAM_DEPTH];
  logic [31:0] lfsr_state;
  int          last_cycles;
  logic        stall_seen;
  logic [7:0]  led_shadow;
  logic [3:0]  latch_shadow;

  xt_soc #(
    .RAM_DEPTH   (RAM_DEPTH),
    .LB_DIV      (LB_DIV),
    .DEBOUNCE_CNT(DEBOUNCE_CNT)
  ) u_xt_soc (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .read_i       (read_i),
    .write_i      (write_i),
    .raddr_i      (raddr_i),
    .waddr_i      (waddr_i),
    .wdata_i      (wdata_i),
    .write_width_i(write_width_i),
    .key_raw_i    (key_raw_i),
    .sw_raw_i     (sw_raw_i),
    .rdata_o      (rdata_o),
    .stall_o      (stall_o),
    .led_o        (led_o)
  );

  always #20 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // expected ram word after a store of the given size
  function automatic logic [31:0] merge_write(input logic [31:0] old_word,
      input logic [31:0] data, input write_width_t width, input logic [1:0] lane);
    logic [31:0] word;
    word = old_word;
    case (width)
      WIDTH_BYTE: word[8*int'(lane) +: 8] = data[7:0];
      WIDTH_HALF: word[16*int'(lane[1]) +: 16] = data[15:0];
      default:    word = data;
    endcase
    return word;
  endfunction

  function automatic logic [31:0] sw_key_word(input logic [3:0] keys, input logic [1:0] sws,
      input logic [3:0] latches);
    return {20'b0, latches, 2'b0, sws, keys};
  endfunction

  task automatic check_value(input string name, input logic [31:0] seen,
      input logic [31:0] expected);
    if (seen !== expected) begin
      $display("** Error at time %0t: %s = 0x%08h, expected 0x%08h",
               $time, name, seen, expected);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // count negedges until stall_o drops
  task automatic wait_finish(input logic [HB_ADDR_WIDTH-1:0] addr);
    int cycles;
    #10;
    stall_seen = stall_o;
    @(negedge clk);
    cycles = 1;
    while (stall_o) begin
      if (cycles >= BUS_TIMEOUT) begin
        $display("bus access to 0x%05h never finished within %0d cycles", addr, BUS_TIMEOUT);
        $display("test failed");
        $fatal(1, "bus access timeout");
      end
      @(negedge clk);
      cycles++;
    end
    last_cycles = cycles;
  endtask

  task automatic bus_write(input logic [HB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
      input write_width_t width);
    @(negedge clk);
    waddr_i       = addr;
    wdata_i       = data;
    write_width_i = width;
    write_i       = 1'b1;
    wait_finish(addr);
    write_i = 1'b0;
  endtask

  task automatic bus_read(input logic [HB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    raddr_i = addr;
    read_i  = 1'b1;
    wait_finish(addr);
    data   = rdata_o;
    read_i = 1'b0;
  endtask

  task automatic ram_write(input logic [7:0] addr, input logic [31:0] data,
      input write_width_t width);
    int idx;
    idx = addr[7:2];
    bus_write(RAM_BASE + addr, data, width);
    ram_model[idx] = merge_write(ram_model[idx], data, width, addr[1:0]);
    check_value("ram write cycles", last_cycles, 1);
  endtask

  task automatic ram_check(input int idx);
    logic [31:0] rd;
    bus_read(RAM_BASE + 4 * idx, rd);
    check_value($sformatf("rdata_o ram word %0d", idx), rd, ram_model[idx]);
    check_value("ram read cycles", last_cycles, 1);
  endtask

  task automatic hold_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  initial begin
    logic [31:0]  data;
    logic [31:0]  rd;
    logic [7:0]   addr;
    write_width_t width;
    clk           = 1'b0;
    rst_n_i       = 1'b0;
    read_i        = 1'b0;
    write_i       = 1'b0;
    raddr_i       = '0;
    waddr_i       = '0;
    wdata_i       = '0;
    write_width_i = WIDTH_WORD;
    key_raw_i     = 4'hf;
    sw_raw_i      = 2'b00;
    lfsr_state    = 32'haec8_5a66;
    led_shadow    = 8'h00;
    latch_shadow  = 4'h0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    // idle state after reset
    check_value("stall_o", stall_o, 0);
    check_value("led_o", led_o, 0);
    bus_read(LB_BASE, rd);
    check_value("rdata_o sw/key", rd, 0);
    bus_read(RAM_BASE, rd);
    check_value("stall_o at ram request", stall_seen, 1);
    check_value("ram read cycles", last_cycles, 1);

    // fill every word, then random stores and loads
    for (int i = 0; i < RAM_DEPTH; i++) begin
      ram_write(8'(4 * i), (i * 32'h9e37_79b1) ^ 32'h0bad_f00d, WIDTH_WORD);
    end
    repeat (200) begin
      case (rand_bits(2))
        0:       width = WIDTH_BYTE;
        1:       width = WIDTH_HALF;
        default: width = WIDTH_WORD;
      endcase
      addr = rand_bits(8);
      if (width == WIDTH_HALF) addr[0] = 1'b0;
      if (width == WIDTH_WORD) addr[1:0] = 2'b00;
      data = rand_bits(32);
      ram_write(addr, data, width);
      ram_check(rand_bits(6));
    end

    // led register
    repeat (6) begin
      data = rand_bits(32);
      bus_write(LB_BASE + 4, data, WIDTH_WORD);
      led_shadow = data[7:0];
      check_value("led_o", led_o, led_shadow);
      bus_read(LB_BASE + 4, rd);
      check_value("rdata_o led", rd, {24'b0, led_shadow});
    end

    // key 1 held, then released
    key_raw_i = 4'b1101;
    hold_cycles(3 * DEBOUNCE_CNT);
    latch_shadow = 4'b0010;
    bus_read(LB_BASE, rd);
    check_value("rdata_o key 1 held", rd, sw_key_word(4'b0010, 2'b00, latch_shadow));
    key_raw_i = 4'hf;
    hold_cycles(3 * DEBOUNCE_CNT);
    bus_read(LB_BASE, rd);
    check_value("rdata_o key 1 released", rd, sw_key_word(4'b0000, 2'b00, latch_shadow));

    // key 3 pressed and released
    key_raw_i = 4'b0111;
    hold_cycles(3 * DEBOUNCE_CNT);
    key_raw_i = 4'hf;
    hold_cycles(3 * DEBOUNCE_CNT);
    latch_shadow = 4'b1010;
    bus_read(LB_BASE, rd);
    check_value("rdata_o key 3 latch", rd, sw_key_word(4'b0000, 2'b00, latch_shadow));

    // short glitch on key 0 is filtered
    key_raw_i = 4'b1110;
    hold_cycles(DEBOUNCE_CNT / 2);
    key_raw_i = 4'hf;
    hold_cycles(3 * DEBOUNCE_CNT);
    bus_read(LB_BASE, rd);
    check_value("rdata_o after glitch", rd, sw_key_word(4'b0000, 2'b00, latch_shadow));

    // clear latch 1 only
    bus_write(LB_BASE, 32'h0000_0200, WIDTH_WORD);
    latch_shadow = 4'b1000;
    bus_read(LB_BASE, rd);
    check_value("rdata_o latch clear", rd, sw_key_word(4'b0000, 2'b00, latch_shadow));

    // switch levels
    sw_raw_i = 2'b10;
    hold_cycles(3 * DEBOUNCE_CNT);
    bus_read(LB_BASE, rd);
    check_value("rdata_o sw 10", rd, sw_key_word(4'b0000, 2'b10, latch_shadow));
    sw_raw_i = 2'b01;
    hold_cycles(3 * DEBOUNCE_CNT);
    bus_read(LB_BASE, rd);
    check_value("rdata_o sw 01", rd, sw_key_word(4'b0000, 2'b01, latch_shadow));

    // unmapped space and unused low-speed offset
    bus_read(UNMAPPED_BASE, rd);
    check_value("rdata_o unmapped", rd, 0);
    check_value("unmapped read cycles", last_cycles, 1);
    bus_read(UNMAPPED_BASE | HB_ADDR_WIDTH'(rand_bits(17)), rd);
    check_value("rdata_o unmapped random", rd, 0);
    bus_write(UNMAPPED_BASE + 8, rand_bits(32), WIDTH_WORD);
    check_value("unmapped write cycles", last_cycles, 1);
    bus_read(LB_BASE + 8, rd);
    check_value("rdata_o unused offset", rd, 0);
    for (int i = 0; i < RAM_DEPTH; i++) begin
      ram_check(i);
    end

    $display("test passed");
    $finish;
  end

endmodule

// ==== xt_soc.f ====
hdl/xt_bus_pkg.sv
hdl/xt_hb.sv
hdl/system_ram_bus.sv
hdl/xt_lb.sv
hdl/sw_key_lbus.sv
hdl/led_lbus.sv
hdl/xt_soc.sv
bench/tb_xt_soc.sv
